/* include/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Word address width, 256 words of memory
`define DMA_ADDR_W 8

// Memory word and control register width
`define DMA_DATA_W 32

// Transfer length in words
`define DMA_LEN_W 8

// Entries in the transfer queue
`define DMA_TF_DEPTH 2

`endif

/* verilog/dma_pkg.sv */
package dma_pkg;

  // Transfer FSM states
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_LOAD    = 3'd1,
    ST_READ    = 3'd2,
    ST_CAPTURE = 3'd3,
    ST_WRITE   = 3'd4,
    ST_DONE    = 3'd5
  } dma_state_e;

  // Control register select
  typedef enum logic [2:0] {
    REG_SRC    = 3'd0,
    REG_DST    = 3'd1,
    REG_LEN    = 3'd2,
    REG_LAUNCH = 3'd3,
    REG_STATUS = 3'd4
  } dma_reg_e;

endpackage : dma_pkg

/* verilog/dma_reg_frontend.sv */
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_reg_frontend
  import dma_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Control port
  input  logic                   ctrl_we_i,
  input  logic                   ctrl_re_i,
  input  dma_reg_e               ctrl_addr_i,
  input  logic [`DMA_DATA_W-1:0] ctrl_wdata_i,
  output logic [`DMA_DATA_W-1:0] ctrl_rdata_o,
  output logic                   ctrl_rvalid_o,
  // Transfer queue head towards the FSM
  output logic                   tf_valid_o,
  output logic [`DMA_ADDR_W-1:0] tf_src_o,
  output logic [`DMA_ADDR_W-1:0] tf_dst_o,
  output logic [`DMA_LEN_W-1:0]  tf_len_o,
  input  logic                   tf_pop_i,
  input  logic                   tf_done_i,
  input  logic                   fsm_busy_i
);

  localparam int unsigned DEPTH  = `DMA_TF_DEPTH;
  localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned FILL_W = $clog2(DEPTH + 1);

  // Programmed transfer parameters
  logic [`DMA_ADDR_W-1:0] src_q;
  logic [`DMA_ADDR_W-1:0] dst_q;
  logic [`DMA_LEN_W-1:0]  len_q;

  // Queue storage, one slot per pending launch
  logic [`DMA_ADDR_W-1:0] q_src_mem [DEPTH];
  logic [`DMA_ADDR_W-1:0] q_dst_mem [DEPTH];
  logic [`DMA_LEN_W-1:0]  q_len_mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [FILL_W-1:0]      fill_q;

  // Entry taken by the last pop, held for the FSM load cycle
  logic [`DMA_ADDR_W-1:0] head_src_q;
  logic [`DMA_ADDR_W-1:0] head_dst_q;
  logic [`DMA_LEN_W-1:0]  head_len_q;

  logic                   launch;
  logic                   q_full;
  logic                   push;
  logic                   pop;
  logic                   ovf_q;
  logic [7:0]             done_cnt_q;
  logic [`DMA_DATA_W-1:0] status;
  logic [`DMA_DATA_W-1:0] rdata_d;
  logic [`DMA_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;

  // Circular pointer advance
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Launch strobe, dropped when no slot is free
  assign launch = ctrl_we_i && (ctrl_addr_i == REG_LAUNCH);
  assign q_full = (fill_q == FILL_W'(DEPTH));
  assign push   = launch && !q_full;
  assign pop    = tf_pop_i && (fill_q != '0);

  // Parameter registers, truncated on write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (ctrl_we_i) begin
      case (ctrl_addr_i)
        REG_SRC: src_q <= ctrl_wdata_i[`DMA_ADDR_W-1:0];
        REG_DST: dst_q <= ctrl_wdata_i[`DMA_ADDR_W-1:0];
        REG_LEN: len_q <= ctrl_wdata_i[`DMA_LEN_W-1:0];
        default: ;
      endcase
    end
  end

  // Queue slots and head hold register
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_src_mem[wr_ptr_q] <= src_q;
      q_dst_mem[wr_ptr_q] <= dst_q;
      q_len_mem[wr_ptr_q] <= len_q;
    end
    if (pop) begin
      head_src_q <= q_src_mem[rd_ptr_q];
      head_dst_q <= q_dst_mem[rd_ptr_q];
      head_len_q <= q_len_mem[rd_ptr_q];
    end
  end

  // Pointers, fill level, overflow flag and completion count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      ovf_q      <= 1'b0;
      done_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: ;
      endcase
      // Sticky until reset
      if (launch && q_full) begin
        ovf_q <= 1'b1;
      end
      // Wraps at 256
      if (tf_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
    end
  end

  assign tf_valid_o = (fill_q != '0);
  assign tf_src_o   = head_src_q;
  assign tf_dst_o   = head_dst_q;
  assign tf_len_o   = head_len_q;

  // Status word, busy while work is queued or running
  always_comb begin
    status       = '0;
    status[0]    = tf_valid_o || fsm_busy_i;
    status[1]    = ovf_q;
    status[15:8] = done_cnt_q;
  end

  // Read-back mux, launch and unmapped selects read zero
  always_comb begin
    case (ctrl_addr_i)
      REG_SRC:    rdata_d = `DMA_DATA_W'(src_q);
      REG_DST:    rdata_d = `DMA_DATA_W'(dst_q);
      REG_LEN:    rdata_d = `DMA_DATA_W'(len_q);
      REG_STATUS: rdata_d = status;
      default:    rdata_d = '0;
    endcase
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= ctrl_re_i;
      if (ctrl_re_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign ctrl_rdata_o  = rdata_q;
  assign ctrl_rvalid_o = rvalid_q;

endmodule : dma_reg_frontend

/* verilog/dma_fsm.sv */
`timescale 1ns/1ps

module dma_fsm
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  // Queue and counter status
  input  logic tf_valid_i,
  input  logic cnt_empty_i,
  input  logic cnt_last_i,
  // Queue handshake
  output logic tf_pop_o,
  output logic tf_done_o,
  output logic fsm_busy_o,
  // Counter control
  output logic cnt_load_o,
  output logic cnt_step_o,
  // Memory port control
  output logic mp_rd_o,
  output logic mp_capture_o,
  output logic mp_wr_o
);

  dma_state_e state_q;
  dma_state_e state_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state and strobe decode, one strobe per state
  always_comb begin
    state_d      = state_q;
    tf_pop_o     = 1'b0;
    tf_done_o    = 1'b0;
    cnt_load_o   = 1'b0;
    cnt_step_o   = 1'b0;
    mp_rd_o      = 1'b0;
    mp_capture_o = 1'b0;
    mp_wr_o      = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // Take the queue head as soon as it shows up
        if (tf_valid_i) begin
          tf_pop_o = 1'b1;
          state_d  = ST_LOAD;
        end
      end
      ST_LOAD: begin
        cnt_load_o = 1'b1;
        // Zero length skips all memory traffic
        state_d    = cnt_empty_i ? ST_DONE : ST_READ;
      end
      ST_READ: begin
        mp_rd_o = 1'b1;
        state_d = ST_CAPTURE;
      end
      ST_CAPTURE: begin
        // Read data arrives one cycle after the request
        mp_capture_o = 1'b1;
        state_d      = ST_WRITE;
      end
      ST_WRITE: begin
        mp_wr_o = 1'b1;
        if (cnt_last_i) begin
          state_d = ST_DONE;
        end else begin
          cnt_step_o = 1'b1;
          state_d    = ST_READ;
        end
      end
      ST_DONE: begin
        tf_done_o = 1'b1;
        state_d   = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign fsm_busy_o = (state_q != ST_IDLE);

endmodule : dma_fsm

/* verilog/dma_beat_counter.sv */
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cnt_load_i,
  input  logic                   cnt_step_i,
  // Transfer taken from the queue
  input  logic [`DMA_ADDR_W-1:0] tf_src_i,
  input  logic [`DMA_ADDR_W-1:0] tf_dst_i,
  input  logic [`DMA_LEN_W-1:0]  tf_len_i,
  // Current word addresses
  output logic [`DMA_ADDR_W-1:0] src_addr_o,
  output logic [`DMA_ADDR_W-1:0] dst_addr_o,
  output logic                   cnt_empty_o,
  output logic                   cnt_last_o
);

  localparam logic [`DMA_LEN_W-1:0] LEN_ONE = 1;

  logic [`DMA_ADDR_W-1:0] src_q;
  logic [`DMA_ADDR_W-1:0] dst_q;
  logic [`DMA_LEN_W-1:0]  remain_q;

  // Addresses wrap modulo the address space
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q    <= '0;
      dst_q    <= '0;
      remain_q <= '0;
    end else if (cnt_load_i) begin
      src_q    <= tf_src_i;
      dst_q    <= tf_dst_i;
      remain_q <= tf_len_i;
    end else if (cnt_step_i) begin
      src_q    <= src_q + 1'b1;
      dst_q    <= dst_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;

  // Empty is checked during the load cycle, so look at the incoming length
  assign cnt_empty_o = cnt_load_i ? (tf_len_i == '0) : (remain_q == '0);
  assign cnt_last_o  = (remain_q == LEN_ONE);

endmodule : dma_beat_counter

/* verilog/dma_mem_port.sv */
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_mem_port (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Access strobes from the FSM
  input  logic                   mp_rd_i,
  input  logic                   mp_wr_i,
  input  logic                   mp_capture_i,
  // Addresses from the counter
  input  logic [`DMA_ADDR_W-1:0] src_addr_i,
  input  logic [`DMA_ADDR_W-1:0] dst_addr_i,
  // Memory interface
  input  logic [`DMA_DATA_W-1:0] mem_rdata_i,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`DMA_ADDR_W-1:0] mem_addr_o,
  output logic [`DMA_DATA_W-1:0] mem_wdata_o
);

  // Word in flight between read and write
  logic [`DMA_DATA_W-1:0] word_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      word_q <= '0;
    end else if (mp_capture_i) begin
      word_q <= mem_rdata_i;
    end
  end

  // One request per read or write state
  assign mem_req_o   = mp_rd_i | mp_wr_i;
  assign mem_we_o    = mp_wr_i;
  // Writes go to the destination, reads come from the source
  assign mem_addr_o  = mp_wr_i ? dst_addr_i : src_addr_i;
  assign mem_wdata_o = word_q;

endmodule : dma_mem_port

/* verilog/dma_core_wrap.sv */
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_core_wrap
  import dma_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Control port
  input  logic                   ctrl_we_i,
  input  logic                   ctrl_re_i,
  input  dma_reg_e               ctrl_addr_i,
  input  logic [`DMA_DATA_W-1:0] ctrl_wdata_i,
  output logic [`DMA_DATA_W-1:0] ctrl_rdata_o,
  output logic                   ctrl_rvalid_o,
  // Memory port
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`DMA_ADDR_W-1:0] mem_addr_o,
  output logic [`DMA_DATA_W-1:0] mem_wdata_o,
  input  logic [`DMA_DATA_W-1:0] mem_rdata_i
);

  // Front end to FSM
  logic                   tf_valid;
  logic [`DMA_ADDR_W-1:0] tf_src;
  logic [`DMA_ADDR_W-1:0] tf_dst;
  logic [`DMA_LEN_W-1:0]  tf_len;
  logic                   tf_pop;
  logic                   tf_done;
  logic                   fsm_busy;

  // FSM to counter
  logic                   cnt_load;
  logic                   cnt_step;
  logic                   cnt_empty;
  logic                   cnt_last;
  logic [`DMA_ADDR_W-1:0] src_addr;
  logic [`DMA_ADDR_W-1:0] dst_addr;

  // FSM to memory port
  logic                   mp_rd;
  logic                   mp_wr;
  logic                   mp_capture;

  // Registers, transfer queue and status
  dma_reg_frontend i_dma_reg_frontend (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ctrl_we_i     ( ctrl_we_i     ),
    .ctrl_re_i     ( ctrl_re_i     ),
    .ctrl_addr_i   ( ctrl_addr_i   ),
    .ctrl_wdata_i  ( ctrl_wdata_i  ),
    .ctrl_rdata_o  ( ctrl_rdata_o  ),
    .ctrl_rvalid_o ( ctrl_rvalid_o ),
    .tf_valid_o    ( tf_valid      ),
    .tf_src_o      ( tf_src        ),
    .tf_dst_o      ( tf_dst        ),
    .tf_len_o      ( tf_len        ),
    .tf_pop_i      ( tf_pop        ),
    .tf_done_i     ( tf_done       ),
    .fsm_busy_i    ( fsm_busy      )
  );

  // Transfer sequencing
  dma_fsm i_dma_fsm (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .tf_valid_i   ( tf_valid   ),
    .cnt_empty_i  ( cnt_empty  ),
    .cnt_last_i   ( cnt_last   ),
    .tf_pop_o     ( tf_pop     ),
    .tf_done_o    ( tf_done    ),
    .fsm_busy_o   ( fsm_busy   ),
    .cnt_load_o   ( cnt_load   ),
    .cnt_step_o   ( cnt_step   ),
    .mp_rd_o      ( mp_rd      ),
    .mp_capture_o ( mp_capture ),
    .mp_wr_o      ( mp_wr      )
  );

  // Word count and address generation
  dma_beat_counter i_dma_beat_counter (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .cnt_load_i  ( cnt_load  ),
    .cnt_step_i  ( cnt_step  ),
    .tf_src_i    ( tf_src    ),
    .tf_dst_i    ( tf_dst    ),
    .tf_len_i    ( tf_len    ),
    .src_addr_o  ( src_addr  ),
    .dst_addr_o  ( dst_addr  ),
    .cnt_empty_o ( cnt_empty ),
    .cnt_last_o  ( cnt_last  )
  );

  // Memory access driver
  dma_mem_port i_dma_mem_port (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .mp_rd_i      ( mp_rd       ),
    .mp_wr_i      ( mp_wr       ),
    .mp_capture_i ( mp_capture  ),
    .src_addr_i   ( src_addr    ),
    .dst_addr_i   ( dst_addr    ),
    .mem_rdata_i  ( mem_rdata_i ),
    .mem_req_o    ( mem_req_o   ),
    .mem_we_o     ( mem_we_o    ),
    .mem_addr_o   ( mem_addr_o  ),
    .mem_wdata_o  ( mem_wdata_o )
  );

endmodule : dma_core_wrap

/* verif/dma_tb.sv */
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb
  import dma_pkg::*;
;

  localparam logic [31:0] SEED      = 32'hd14281b3;
  localparam int          MEM_WORDS = 1 << `DMA_ADDR_W;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   ctrl_we_i;
  logic                   ctrl_re_i;
  dma_reg_e               ctrl_addr_i;
  logic [`DMA_DATA_W-1:0] ctrl_wdata_i;
  logic [`DMA_DATA_W-1:0] ctrl_rdata_o;
  logic                   ctrl_rvalid_o;
  logic                   mem_req_o;
  logic                   mem_we_o;
  logic [`DMA_ADDR_W-1:0] mem_addr_o;
  logic [`DMA_DATA_W-1:0] mem_wdata_o;
  logic [`DMA_DATA_W-1:0] mem_rdata_i = '0;

  // Memory behind the DMA and its reference copy
  logic [`DMA_DATA_W-1:0] mem     [MEM_WORDS];
  logic [`DMA_DATA_W-1:0] ref_mem [MEM_WORDS];
  // Requests seen on the memory port
  int                     mem_accesses = 0;

  // Shadow of the programmed registers
  logic [`DMA_ADDR_W-1:0] sh_src = '0;
  logic [`DMA_ADDR_W-1:0] sh_dst = '0;
  logic [`DMA_LEN_W-1:0]  sh_len = '0;

  // Queue occupancy model holding the lengths of pending launches
  int                     m_qlen [$];
  int                     m_busy_left = 0;
  int                     m_accepted  = 0;
  // One read and one write per word of every accepted launch
  int                     m_accesses  = 0;
  logic                   m_ovf       = 1'b0;
  logic [7:0]             m_done      = '0;

  logic [31:0]            rng_state = SEED;
  int                     cycles    = 0;
  // Grows with every control access and launch
  int                     budget    = 200;

  dma_core_wrap UUT (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ctrl_we_i     ( ctrl_we_i     ),
    .ctrl_re_i     ( ctrl_re_i     ),
    .ctrl_addr_i   ( ctrl_addr_i   ),
    .ctrl_wdata_i  ( ctrl_wdata_i  ),
    .ctrl_rdata_o  ( ctrl_rdata_o  ),
    .ctrl_rvalid_o ( ctrl_rvalid_o ),
    .mem_req_o     ( mem_req_o     ),
    .mem_we_o      ( mem_we_o      ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .mem_rdata_i   ( mem_rdata_i   )
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > budget) begin
      $display("CHECKS FAILED");
      $fatal(1, "Timeout after %0d cycles, the DMA never went idle", cycles);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_rand();
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  // Initial contents hashed from the full word address
  function automatic logic [31:0] fill_word(input logic [`DMA_ADDR_W-1:0] addr);
    return xorshift32(SEED ^ 32'(addr));
  endfunction

  // Memory with one cycle read latency driven on the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(`DMA_ADDR_W'(i));
      end
      mem_rdata_i <= '0;
    end else if (mem_req_o) begin
      mem_accesses <= mem_accesses + 1;
      if (mem_we_o) begin
        mem[mem_addr_o] <= mem_wdata_o;
      end else begin
        mem_rdata_i <= mem[mem_addr_o];
      end
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // STATUS as the model sees it at the start of a cycle
  function automatic logic [31:0] model_status();
    logic busy;
    busy = (m_qlen.size() != 0) || (m_busy_left != 0);
    return {16'd0, m_done, 6'd0, m_ovf, busy};
  endfunction

  // One cycle of the queue and FSM occupancy
  task automatic model_cycle(input logic launch);
    logic                   accept;
    logic [`DMA_ADDR_W-1:0] s;
    logic [`DMA_ADDR_W-1:0] d;
    accept = launch && (m_qlen.size() < `DMA_TF_DEPTH);
    if (m_busy_left != 0) begin
      // Last busy cycle is ST_DONE
      if (m_busy_left == 1) begin
        m_done = m_done + 8'd1;
      end
      m_busy_left = m_busy_left - 1;
    end else if (m_qlen.size() != 0) begin
      // Load cycle plus 3 cycles per word plus the done cycle
      m_busy_left = 3 * m_qlen.pop_front() + 2;
    end
    if (launch) begin
      budget = budget + 3 * int'(sh_len) + 3;
    end
    if (launch && !accept) begin
      m_ovf = 1'b1;
    end
    if (accept) begin
      m_qlen.push_back(int'(sh_len));
      m_accepted = m_accepted + 1;
      m_accesses = m_accesses + 2 * int'(sh_len);
      // Ascending word copy with wrapping addresses
      for (int i = 0; i < int'(sh_len); i++) begin
        s = sh_src + `DMA_ADDR_W'(i);
        d = sh_dst + `DMA_ADDR_W'(i);
        ref_mem[d] = ref_mem[s];
      end
    end
  endtask

  // Drive one control cycle on the falling edge
  task automatic drive_cycle(input logic we, input logic re, input dma_reg_e addr,
                             input logic [31:0] wdata);
    ctrl_we_i    = we;
    ctrl_re_i    = re;
    ctrl_addr_i  = addr;
    ctrl_wdata_i = wdata;
    model_cycle(we && (addr == REG_LAUNCH));
    if (we) begin
      case (addr)
        REG_SRC: sh_src = wdata[`DMA_ADDR_W-1:0];
        REG_DST: sh_dst = wdata[`DMA_ADDR_W-1:0];
        REG_LEN: sh_len = wdata[`DMA_LEN_W-1:0];
        default: ;
      endcase
    end
    @(negedge clk_i);
    ctrl_we_i = 1'b0;
    ctrl_re_i = 1'b0;
  endtask

  task automatic write_reg(input dma_reg_e addr, input logic [31:0] wdata);
    budget = budget + 50;
    drive_cycle(1'b1, 1'b0, addr, wdata);
  endtask

  // Read one register and compare with the shadow or the model
  task automatic read_check(input string name, input dma_reg_e addr,
                            output logic [31:0] data);
    logic [31:0] exp;
    case (addr)
      REG_SRC:    exp = 32'(sh_src);
      REG_DST:    exp = 32'(sh_dst);
      REG_LEN:    exp = 32'(sh_len);
      REG_STATUS: exp = model_status();
      default:    exp = '0;
    endcase
    drive_cycle(1'b0, 1'b1, addr, '0);
    check_eq({name, " rvalid"}, 32'd1, 32'(ctrl_rvalid_o));
    check_eq(name, exp, ctrl_rdata_o);
    data = ctrl_rdata_o;
  endtask

  task automatic read_reg(input string name, input dma_reg_e addr, output logic [31:0] data);
    budget = budget + 50;
    read_check(name, addr, data);
  endtask

  // Poll STATUS until busy drops
  task automatic wait_idle(input string name);
    logic [31:0] st;
    st = 32'd1;
    while (st[0]) begin
      read_check(name, REG_STATUS, st);
    end
  endtask

  task automatic launch_xfer(input logic [`DMA_ADDR_W-1:0] src,
                             input logic [`DMA_ADDR_W-1:0] dst,
                             input logic [`DMA_LEN_W-1:0] len);
    write_reg(REG_SRC, 32'(src));
    write_reg(REG_DST, 32'(dst));
    write_reg(REG_LEN, 32'(len));
    write_reg(REG_LAUNCH, next_rand());
  endtask

  task automatic compare_mem(input string name);
    check_eq({name, " memory accesses"}, 32'(m_accesses), 32'(mem_accesses));
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_eq($sformatf("%s mem[%0d]", name, i), ref_mem[i], mem[i]);
    end
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'(next_rand());
  endfunction

  initial begin
    logic [31:0]            st;
    logic [31:0]            scratch;
    logic [7:0]             done0;
    logic [`DMA_ADDR_W-1:0] a;
    logic [`DMA_ADDR_W-1:0] b;
    logic [`DMA_ADDR_W-1:0] c;
    logic [`DMA_LEN_W-1:0]  l1;
    logic [`DMA_LEN_W-1:0]  l2;

    rst_n_i      = 1'b0;
    ctrl_we_i    = 1'b0;
    ctrl_re_i    = 1'b0;
    ctrl_addr_i  = REG_SRC;
    ctrl_wdata_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(`DMA_ADDR_W'(i));
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Register read-back and reset value of STATUS
    read_reg("t1 status", REG_STATUS, st);
    check_eq("t1 status after reset", 32'd0, st);
    for (int k = 0; k < 4; k++) begin
      write_reg(REG_SRC, next_rand());
      write_reg(REG_DST, next_rand());
      write_reg(REG_LEN, next_rand());
      read_reg("t1 src", REG_SRC, scratch);
      read_reg("t1 dst", REG_DST, scratch);
      read_reg("t1 len", REG_LEN, scratch);
      read_reg("t1 launch", REG_LAUNCH, scratch);
    end

    // Single transfer
    a  = rand_byte();
    b  = rand_byte();
    l1 = `DMA_LEN_W'(rand_range(1, 16));
    launch_xfer(a, b, l1);
    wait_idle("t2 status");
    compare_mem("t2");

    // Back to back launches where the second reads what the first wrote
    read_reg("t3 status", REG_STATUS, st);
    done0 = m_done;
    a  = rand_byte();
    b  = rand_byte();
    c  = rand_byte();
    l1 = `DMA_LEN_W'(rand_range(1, 16));
    l2 = `DMA_LEN_W'(rand_range(1, 16));
    launch_xfer(a, b, l1);
    launch_xfer(b, c, l2);
    wait_idle("t3 status");
    read_reg("t3 status", REG_STATUS, st);
    check_eq("t3 done count", 32'(8'(done0 + 8'd2)), 32'(st[15:8]));
    compare_mem("t3");

    // Four launches in a row with the destination one below the source
    read_reg("t4 status", REG_STATUS, st);
    done0 = m_done;
    a     = rand_byte();
    l1    = `DMA_LEN_W'(rand_range(4, 8));
    write_reg(REG_SRC, 32'(a));
    write_reg(REG_DST, 32'(a - 8'd1));
    write_reg(REG_LEN, 32'(l1));
    repeat (4) write_reg(REG_LAUNCH, next_rand());
    wait_idle("t4 status");
    read_reg("t4 status", REG_STATUS, st);
    check_eq("t4 overflow", 32'd1, 32'(st[1]));
    check_eq("t4 done count", 32'(8'(done0 + 8'd3)), 32'(st[15:8]));
    compare_mem("t4");

    // Zero length
    read_reg("t5 status", REG_STATUS, st);
    done0 = m_done;
    launch_xfer(rand_byte(), rand_byte(), '0);
    wait_idle("t5 status");
    read_reg("t5 status", REG_STATUS, st);
    check_eq("t5 done count", 32'(8'(done0 + 8'd1)), 32'(st[15:8]));
    compare_mem("t5");

    // Random traffic with random gaps where drops are allowed
    repeat (20) begin
      launch_xfer(rand_byte(), rand_byte(), `DMA_LEN_W'(rand_range(1, 16)));
      repeat (rand_range(0, 30)) drive_cycle(1'b0, 1'b0, REG_STATUS, '0);
    end
    wait_idle("t6 status");
    read_reg("t6 status", REG_STATUS, st);
    check_eq("t6 done count", 32'(8'(m_accepted)), 32'(st[15:8]));
    check_eq("t6 overflow", 32'd1, 32'(st[1]));
    compare_mem("t6");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : dma_tb

/* vlog.f */
+incdir+include
verilog/dma_pkg.sv
verilog/dma_reg_frontend.sv
verilog/dma_fsm.sv
verilog/dma_beat_counter.sv
verilog/dma_mem_port.sv
verilog/dma_core_wrap.sv
verif/dma_tb.sv

/* run_verilator.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator
# The exit status is the simulator's, non-zero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal -f vlog.f \
  --top-module dma_tb -Mdir obj_dir -o dma_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/dma_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
